//--- vlog.f
design/nr_timing_pkg.sv
design/frame_timer.sv
design/symbol_timer.sv
design/nr_marker_gen.sv
verification/nr_marker_checker.sv
verification/nr_marker_gen_tb.sv

//--- Makefile
BIN  := obj_dir/Vnr_marker_gen_tb
SRCS := $(shell cat vlog.f)

.PHONY: run clean

run: $(BIN)
	out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

$(BIN): vlog.f $(SRCS)
	verilator --binary --assert --timescale 1ns/10ps --top-module nr_marker_gen_tb \
		--Mdir obj_dir -f vlog.f

clean:
	rm -rf obj_dir

//--- verification/nr_marker_gen_tb.sv
`timescale 1ns/10ps

module nr_marker_gen_tb;

    import nr_timing_pkg::*;

    // scaled lengths give a 960 cycle frame
    localparam int unsigned slot_len            = 240;
    localparam int unsigned slots_per_subframe  = 2;
    localparam int unsigned subframes_per_frame = 2;
    localparam int unsigned sym_len_first       = 32;
    localparam int unsigned sym_len             = 16;
    localparam int unsigned cp_len_first        = 8;
    localparam int unsigned cp_len              = 4;
    localparam int unsigned frame_len = slot_len * slots_per_subframe * subframes_per_frame;
    localparam int unsigned cycle_limit = 5 * 3 * frame_len + 1000;  // 5 tests of 3 frames

    logic           clk = 1'b0;
    logic           rst_n;
    logic           car_en;
    logic           frm_mrkr;
    frame_timing_t  frame;
    symbol_timing_t symbol;
    int             err_cnt;                 // from the checker
    int             seed = 32'h696e;
    int unsigned    cycles = 0;
    int             tests_run = 0;
    int             tests_failed = 0;
    int             local_errs = 0;          // stimulus side failures in this test
    int             err_base = 0;            // checker count at test start

    always #4 clk = ~clk;

    nr_marker_gen #(
        .slot_len            (slot_len),
        .slots_per_subframe  (slots_per_subframe),
        .subframes_per_frame (subframes_per_frame),
        .sym_len_first       (sym_len_first),
        .sym_len             (sym_len),
        .cp_len_first        (cp_len_first),
        .cp_len              (cp_len)
    ) i_nr_marker_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .car_en   (car_en),
        .frm_mrkr (frm_mrkr),
        .frame    (frame),
        .symbol   (symbol)
    );

    nr_marker_checker #(
        .slot_len            (slot_len),
        .slots_per_subframe  (slots_per_subframe),
        .subframes_per_frame (subframes_per_frame),
        .sym_len_first       (sym_len_first),
        .sym_len             (sym_len),
        .cp_len_first        (cp_len_first),
        .cp_len              (cp_len)
    ) i_nr_marker_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .car_en   (car_en),
        .frm_mrkr (frm_mrkr),
        .frame    (frame),
        .symbol   (symbol),
        .err_cnt  (err_cnt)
    );

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned v;
        v = $random(seed);
        return v % n;
    endfunction

    task automatic idle_cycles(input int unsigned n);
        repeat (n) @(negedge clk);
    endtask

    task automatic pulse_marker();
        @(negedge clk) frm_mrkr = 1'b1;    // one cycle wide
        @(negedge clk) frm_mrkr = 1'b0;
    endtask

    // frame strobe with a bounded wait
    task automatic wait_frame_stb(input int unsigned limit);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (!frame.frame_stb && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!frame.frame_stb) begin
            local_errs++;
            $display("no frame strobe seen within %0d cycles", limit);
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        @(posedge clk);                     // checker counts move on the falling edge
        errs = err_cnt - err_base + local_errs;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errs);
        end
        err_base   = err_cnt;
        local_errs = 0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, tests did not complete", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        rst_n    = 1'b0;
        car_en   = 1'b0;
        frm_mrkr = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        // carrier flips at random but no marker ever arrives
        repeat (200) @(negedge clk) car_en = 1'($random(seed));
        finish_test("quiet after reset");
        @(negedge clk) car_en = 1'b1;
        pulse_marker();
        wait_frame_stb(8);                  // lands 2 cycles after the marker
        idle_cycles(3 * frame_len);
        finish_test("frame periodicity");
        wait_frame_stb(frame_len + 8);
        idle_cycles(frame_len);
        finish_test("symbol boundaries");
        // markers on the frame grid land on the last sample of each frame
        repeat (2) begin
            wait_frame_stb(frame_len + 8);
            idle_cycles(frame_len - 3);
            pulse_marker();
        end
        finish_test("cp window and 4x strobe");
        idle_cycles(1 + rand_below(frame_len));
        @(negedge clk) car_en = 1'b0;       // drop the carrier mid frame
        idle_cycles(50 + rand_below(200));
        @(negedge clk) car_en = 1'b1;       // back on with still no marker
        idle_cycles(300);
        pulse_marker();
        wait_frame_stb(8);
        idle_cycles(100 + rand_below(700)); // realign mid frame
        pulse_marker();
        wait_frame_stb(8);
        idle_cycles(frame_len + 20);
        finish_test("disable and realign");
        $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verification/nr_marker_checker.sv
`timescale 1ns/10ps

module nr_marker_checker #(
    parameter int unsigned slot_len            = 61440,
    parameter int unsigned slots_per_subframe  = 2,
    parameter int unsigned subframes_per_frame = 10,
    parameter int unsigned sym_len_first       = 4448,
    parameter int unsigned sym_len             = 4384,
    parameter int unsigned cp_len_first        = 352,
    parameter int unsigned cp_len              = 288
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          car_en,
    input  logic                          frm_mrkr,
    input  nr_timing_pkg::frame_timing_t  frame,     // DUT outputs under check
    input  nr_timing_pkg::symbol_timing_t symbol,
    output int                            err_cnt    // running mismatch count
);

    import nr_timing_pkg::*;

    localparam int unsigned sf_len    = slot_len * slots_per_subframe;
    localparam int unsigned frame_len = sf_len * subframes_per_frame;

    int unsigned    ph = 0;          // samples since the last accepted marker
    logic           run_m = 1'b0;    // model of the enable latch
    logic           armed = 1'b0;    // outputs are defined once reset was seen
    int unsigned    cyc = 0;
    int             errors = 0;
    frame_timing_t  exp_frame;
    symbol_timing_t exp_sym;

    assign err_cnt = errors;

    // frame level view of a phase since every period divides the frame evenly
    function automatic frame_timing_t frame_expect(input int unsigned p);
        frame_timing_t f;
        f.frame_stb = (p == 0);
        f.frame_cnt = frame_cnt_w'(p);
        f.sf_stb    = (p % sf_len == 0);
        f.sf_cnt    = sf_cnt_w'(p % sf_len);
        f.sf_idx    = sf_idx_w'(p / sf_len);
        f.slot_stb  = (p % slot_len == 0);
        f.slot_cnt  = slot_cnt_w'(p % slot_len);
        f.slot_idx  = slot_idx_w'(p / slot_len);
        return f;
    endfunction

    // symbol 0 starts at 0 and symbol k at sym_len_first + (k-1)*sym_len
    function automatic symbol_timing_t sym_expect(input int unsigned sp);
        int unsigned    k;
        int unsigned    start;
        int unsigned    len;
        int unsigned    off;
        symbol_timing_t s;
        if (sp < sym_len_first) begin
            k     = 0;
            start = 0;
            len   = sym_len_first;
        end else begin
            k     = 1 + (sp - sym_len_first) / sym_len;
            start = sym_len_first + (k - 1) * sym_len;
            len   = sym_len;
        end
        off         = sp - start;
        s.sym_stb   = (off == 0);
        s.pre_stb   = (off == len - 1);            // last sample before next start
        s.sym_cnt   = sym_cnt_w'(off);
        s.sym_idx   = sym_idx_w'(k);
        s.cp_win    = (off < ((k == 0) ? cp_len_first : cp_len));
        s.sym4x_stb = (off % (len / 4) == 0);      // quarter points of the symbol
        return s;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h (cycle %0d)", name, got, exp, cyc);
        end
    endtask

    // model steps on the rising edge with outputs one register behind the phase
    always @(posedge clk) begin
        cyc++;
        if (!rst_n) begin
            armed     = 1'b1;
            exp_frame = '0;
            exp_sym   = '0;
            run_m     = 1'b0;
            ph        = 0;
        end else begin
            exp_frame = run_m ? frame_expect(ph) : '0;       // quiet while idle
            exp_sym   = run_m ? sym_expect(ph % slot_len) : '0;
            // a marker or an idle carrier restarts the phase
            ph = ((car_en && frm_mrkr) || !run_m) ? 0 : (ph + 1) % frame_len;
            if (car_en && frm_mrkr) begin
                run_m = 1'b1;
            end else if (!car_en) begin
                run_m = 1'b0;
            end
        end
    end

    // compare mid cycle where the registered outputs are settled
    always @(negedge clk) begin
        if (armed) begin
            check_field("frame_stb", 32'(frame.frame_stb), 32'(exp_frame.frame_stb));
            check_field("frame_cnt", 32'(frame.frame_cnt), 32'(exp_frame.frame_cnt));
            check_field("sf_stb", 32'(frame.sf_stb), 32'(exp_frame.sf_stb));
            check_field("sf_cnt", 32'(frame.sf_cnt), 32'(exp_frame.sf_cnt));
            check_field("sf_idx", 32'(frame.sf_idx), 32'(exp_frame.sf_idx));
            check_field("slot_stb", 32'(frame.slot_stb), 32'(exp_frame.slot_stb));
            check_field("slot_cnt", 32'(frame.slot_cnt), 32'(exp_frame.slot_cnt));
            check_field("slot_idx", 32'(frame.slot_idx), 32'(exp_frame.slot_idx));
            check_field("sym_stb", 32'(symbol.sym_stb), 32'(exp_sym.sym_stb));
            check_field("pre_stb", 32'(symbol.pre_stb), 32'(exp_sym.pre_stb));
            check_field("sym_cnt", 32'(symbol.sym_cnt), 32'(exp_sym.sym_cnt));
            check_field("sym_idx", 32'(symbol.sym_idx), 32'(exp_sym.sym_idx));
            check_field("cp_win", 32'(symbol.cp_win), 32'(exp_sym.cp_win));
            check_field("sym4x_stb", 32'(symbol.sym4x_stb), 32'(exp_sym.sym4x_stb));
        end
    end

endmodule

//--- design/nr_marker_gen.sv
`timescale 1ns/10ps

module nr_marker_gen #(
    parameter int unsigned slot_len            = 61440,  // 0.5 ms at 122.88 MS/s
    parameter int unsigned slots_per_subframe  = 2,
    parameter int unsigned subframes_per_frame = 10,
    parameter int unsigned sym_len_first       = 4448,   // 4096 + 352
    parameter int unsigned sym_len             = 4384,   // 4096 + 288
    parameter int unsigned cp_len_first        = 352,
    parameter int unsigned cp_len              = 288
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          car_en,    // carrier enable
    input  logic                          frm_mrkr,  // 10 ms frame pulse
    output nr_timing_pkg::frame_timing_t  frame,     // frame, subframe, slot
    output nr_timing_pkg::symbol_timing_t symbol     // symbol, cp, 4x
);

    import nr_timing_pkg::*;

    logic                  run;         // enable latch state
    logic [slot_cnt_w-1:0] slot_pos;    // live slot count
    logic                  slot_start;  // live slot wrap

    // counters and frame level strobes
    frame_timer #(
        .slot_len            (slot_len),
        .slots_per_subframe  (slots_per_subframe),
        .subframes_per_frame (subframes_per_frame)
    ) i_frame_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .car_en     (car_en),
        .frm_mrkr   (frm_mrkr),
        .run        (run),
        .slot_pos   (slot_pos),
        .slot_start (slot_start),
        .frame      (frame)
    );

    // symbol placement inside each slot
    symbol_timer #(
        .sym_len_first (sym_len_first),
        .sym_len       (sym_len),
        .cp_len_first  (cp_len_first),
        .cp_len        (cp_len)
    ) i_symbol_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .slot_pos   (slot_pos),
        .slot_start (slot_start),
        .symbol     (symbol)
    );

endmodule

//--- design/symbol_timer.sv
`timescale 1ns/10ps

module symbol_timer #(
    parameter int unsigned sym_len_first = 4448,  // symbol 0 incl cp
    parameter int unsigned sym_len       = 4384,  // symbols 1..13 incl cp
    parameter int unsigned cp_len_first  = 352,
    parameter int unsigned cp_len        = 288
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 run,         // from frame timer
    input  logic [nr_timing_pkg::slot_cnt_w-1:0] slot_pos,    // live slot sample
    input  logic                                 slot_start,  // live slot wrap
    output nr_timing_pkg::symbol_timing_t        symbol
);

    import nr_timing_pkg::*;

    // boundary arithmetic is done in slot sample units
    localparam logic [slot_cnt_w-1:0] first_bnd = slot_cnt_w'(sym_len_first);
    localparam logic [slot_cnt_w-1:0] bnd_step  = slot_cnt_w'(sym_len);

    // per symbol lengths in symbol sample units
    localparam logic [sym_cnt_w-1:0] len_first = sym_cnt_w'(sym_len_first);
    localparam logic [sym_cnt_w-1:0] len_norm  = sym_cnt_w'(sym_len);
    localparam logic [sym_cnt_w-1:0] cp_first  = sym_cnt_w'(cp_len_first);
    localparam logic [sym_cnt_w-1:0] cp_norm   = sym_cnt_w'(cp_len);

    logic [slot_cnt_w-1:0] next_bnd;   // slot position of the next symbol start
    logic [slot_cnt_w-1:0] prev_bnd;   // slot position of the current symbol start
    logic                  at_bnd;     // live position hits the next boundary
    logic                  pre_bnd;    // one sample before the next boundary
    logic                  first_sym;  // current symbol is symbol 0
    logic [sym_cnt_w-1:0]  cur_len;
    logic [sym_cnt_w-1:0]  cur_cp;
    logic [sym_cnt_w-1:0]  sym_off;    // live offset into current symbol
    logic [sym_cnt_w-1:0]  q1_off;
    logic [sym_cnt_w-1:0]  q2_off;
    logic [sym_cnt_w-1:0]  q3_off;

    assign at_bnd  = (slot_pos == next_bnd);
    // after symbol 13 next_bnd equals the slot length, so this also
    // catches the last sample before the slot wraps
    assign pre_bnd = (slot_pos == next_bnd - slot_cnt_w'(1));

    // first or normal lengths, picked from the registered index
    assign first_sym = (symbol.sym_idx == '0);
    assign cur_len   = first_sym ? len_first : len_norm;
    assign cur_cp    = first_sym ? cp_first : cp_norm;

    // offset stays below one symbol length, truncation is safe
    assign sym_off = sym_cnt_w'(slot_pos - prev_bnd);

    // quarter points, lengths are multiples of 4
    assign q1_off = cur_len >> 2;
    assign q2_off = cur_len >> 1;
    assign q3_off = q1_off + q2_off;

    always_ff @(posedge clk) begin
        if (!rst_n || !run) begin
            next_bnd <= first_bnd;
            prev_bnd <= '0;
            symbol   <= '0;                      // quiet while idle
        end else if (slot_start) begin           // slot wrap or realign, symbol 0
            next_bnd         <= first_bnd;
            prev_bnd         <= '0;
            symbol.sym_stb   <= 1'b1;
            symbol.pre_stb   <= 1'b0;
            symbol.sym_cnt   <= '0;
            symbol.sym_idx   <= '0;
            symbol.cp_win    <= 1'b1;
            symbol.sym4x_stb <= 1'b1;
        end else if (at_bnd) begin               // symbols 1..13
            next_bnd         <= next_bnd + bnd_step;
            prev_bnd         <= next_bnd;
            symbol.sym_stb   <= 1'b1;
            symbol.pre_stb   <= 1'b0;
            symbol.sym_cnt   <= '0;
            symbol.sym_idx   <= symbol.sym_idx + 1'b1;
            symbol.cp_win    <= 1'b1;
            symbol.sym4x_stb <= 1'b1;
        end else begin
            symbol.sym_stb   <= 1'b0;
            symbol.pre_stb   <= pre_bnd;
            symbol.sym_cnt   <= sym_off;
            symbol.cp_win    <= (sym_off < cur_cp);
            symbol.sym4x_stb <= (sym_off == q1_off) ||
                                (sym_off == q2_off) ||
                                (sym_off == q3_off);
        end
    end

    // index never passes the last symbol of the slot
    a_sym_idx_range : assert property (@(posedge clk) disable iff (!rst_n)
        symbol.sym_idx < sym_idx_w'(syms_per_slot))
        else $error("symbol index %0d out of range", symbol.sym_idx);

    // a pre strobe is followed by a symbol strobe unless the carrier went off
    a_pre_then_sym : assert property (@(posedge clk) disable iff (!rst_n)
        (symbol.pre_stb && run) |=> symbol.sym_stb)
        else $error("pre symbol strobe not followed by symbol strobe");

endmodule

//--- design/frame_timer.sv
`timescale 1ns/10ps

module frame_timer #(
    parameter int unsigned slot_len            = 61440,  // samples per slot
    parameter int unsigned slots_per_subframe  = 2,
    parameter int unsigned subframes_per_frame = 10
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 car_en,      // carrier enable
    input  logic                                 frm_mrkr,    // 10 ms pulse
    output logic                                 run,         // timing active
    output logic [nr_timing_pkg::slot_cnt_w-1:0] slot_pos,    // live slot sample
    output logic                                 slot_start,  // live slot wrap
    output nr_timing_pkg::frame_timing_t         frame
);

    import nr_timing_pkg::*;

    localparam int unsigned sf_len          = slot_len * slots_per_subframe;
    localparam int unsigned frame_len       = sf_len * subframes_per_frame;
    localparam int unsigned slots_per_frame = slots_per_subframe * subframes_per_frame;

    // last sample of each period, where the counter wraps
    localparam logic [frame_cnt_w-1:0] frame_last = frame_cnt_w'(frame_len - 1);
    localparam logic [sf_cnt_w-1:0]    sf_last    = sf_cnt_w'(sf_len - 1);
    localparam logic [slot_cnt_w-1:0]  slot_last  = slot_cnt_w'(slot_len - 1);
    localparam logic [slot_idx_w-1:0]  slot_idx_max = slot_idx_w'(slots_per_frame - 1);

    logic                   align;        // marker taken while carrier is on
    logic [frame_cnt_w-1:0] frame_pos;    // live frame sample count
    logic [sf_cnt_w-1:0]    sf_pos;       // live subframe sample count
    logic                   frame_start;
    logic                   sf_start;

    assign align = frm_mrkr & car_en;

    // enable latch, set by an accepted marker and held until car_en drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (align) begin
            run <= 1'b1;
        end else if (!car_en) begin
            run <= 1'b0;
        end
    end

    // sample counters
    // a marker restarts all three at once, so a mid frame marker realigns them
    always_ff @(posedge clk) begin
        if (!rst_n || align || !run) begin
            frame_pos <= '0;
            sf_pos    <= '0;
            slot_pos  <= '0;
        end else begin
            frame_pos <= (frame_pos == frame_last) ? '0 : frame_pos + 1'b1;
            sf_pos    <= (sf_pos == sf_last) ? '0 : sf_pos + 1'b1;
            slot_pos  <= (slot_pos == slot_last) ? '0 : slot_pos + 1'b1;
        end
    end

    // counters sit at 0 while idle, so every start is qualified with run
    assign frame_start = run && (frame_pos == '0);
    assign sf_start    = run && (sf_pos == '0);
    assign slot_start  = run && (slot_pos == '0);

    // output stage, one cycle behind the live counters
    always_ff @(posedge clk) begin
        if (!rst_n || !run) begin
            frame <= '0;                              // idle, all quiet
        end else begin
            frame.frame_stb <= frame_start;
            frame.frame_cnt <= frame_pos;
            frame.sf_stb    <= sf_start;
            frame.sf_cnt    <= sf_pos;
            frame.slot_stb  <= slot_start;
            frame.slot_cnt  <= slot_pos;
            if (frame_start) begin                    // indices restart per frame
                frame.sf_idx   <= '0;
                frame.slot_idx <= '0;
            end else begin
                if (sf_start) begin
                    frame.sf_idx <= frame.sf_idx + 1'b1;
                end
                if (slot_start) begin
                    frame.slot_idx <= frame.slot_idx + 1'b1;
                end
            end
        end
    end

    // slot index never runs past the last slot of the frame
    a_slot_idx_range : assert property (@(posedge clk) disable iff (!rst_n)
        frame.slot_idx <= slot_idx_max)
        else $error("slot index %0d out of range", frame.slot_idx);

    // subframe boundaries are always slot boundaries
    a_sf_on_slot : assert property (@(posedge clk) disable iff (!rst_n)
        frame.sf_stb |-> frame.slot_stb)
        else $error("subframe strobe without slot strobe");

endmodule

//--- design/nr_timing_pkg.sv
package nr_timing_pkg;

    // count widths sized for 122.88 MS/s, the scaled test lengths fit as well
    localparam int frame_cnt_w   = 23;  // 10 ms = 1228800 samples
    localparam int sf_cnt_w      = 19;  // 1 ms = 122880 samples
    localparam int slot_cnt_w    = 18;  // 0.5 ms = 61440 samples
    localparam int sym_cnt_w     = 16;  // longest symbol including cp
    localparam int sf_idx_w      = 4;   // subframe 0..9
    localparam int slot_idx_w    = 5;   // slot 0..19
    localparam int sym_idx_w     = 4;   // symbol 0..13
    localparam int syms_per_slot = 14;  // normal cp only

    // frame level timing, all fields registered together
    typedef struct packed {
        logic                  frame_stb;   // one cycle at frame start
        logic [frame_cnt_w-1:0] frame_cnt;  // sample within frame
        logic                  sf_stb;      // one cycle every subframe
        logic [sf_cnt_w-1:0]   sf_cnt;      // sample within subframe
        logic [sf_idx_w-1:0]   sf_idx;
        logic                  slot_stb;    // one cycle every slot
        logic [slot_cnt_w-1:0] slot_cnt;    // sample within slot
        logic [slot_idx_w-1:0] slot_idx;
    } frame_timing_t;

    // symbol level timing, lines up with the slot strobe above
    typedef struct packed {
        logic                  sym_stb;     // first sample of a symbol
        logic                  pre_stb;     // one cycle ahead of sym_stb
        logic [sym_cnt_w-1:0]  sym_cnt;     // sample within symbol
        logic [sym_idx_w-1:0]  sym_idx;
        logic                  cp_win;      // high over the cyclic prefix
        logic                  sym4x_stb;   // quarter symbol ticks
    } symbol_timing_t;

    // 72 bits and 24 bits wide

endpackage
